//--- src/alu_pkg.sv
/* alu_pkg: shared types for the two-stage integer ALU.
   Operation and condition encodings, flag word and stage structs. */

`default_nettype none

package alu_pkg;

  localparam int DATA_W = 64;
  localparam int HALF_W = 32;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [HALF_W-1:0] half_t;

  typedef enum logic [3:0] {
    OP_ADD64,
    OP_ADD32,
    OP_SUB64,
    OP_SUB32,
    OP_AND64,
    OP_AND32,
    OP_OR64,
    OP_OR32,
    OP_XOR64,
    OP_XOR32,
    OP_MOV64,
    OP_CMOV64,
    OP_CSET
  } alu_op_t;

  // order fixes the encoding, 0..15
  typedef enum logic [3:0] {
    COND_Z, COND_NZ, COND_S, COND_NS,
    COND_UGT, COND_ULE, COND_UGE, COND_ULT,
    COND_SGT, COND_SLE, COND_SGE, COND_SLT,
    COND_O, COND_NO, COND_P, COND_ALWAYS
  } cond_t;

  typedef struct packed {
    logic c;
    logic o;
    logic a;
    logic s;
    logic z;
    logic p;
  } flags_t;

  typedef struct packed {
    alu_op_t op;
    cond_t   cond;
    data_t   a;
    data_t   b;
    flags_t  flags_in;
  } alu_req_t;

  typedef struct packed {
    alu_op_t op;
    data_t   result;    // raw, before 32-bit truncation
    logic    c63;
    logic    c31;
    logic    c3;
    logic    a_sign63;
    logic    b_sign63;
    logic    a_sign31;
    logic    b_sign31;
    logic    cond_true;
    flags_t  flags_in;
  } alu_exec_t;

  typedef struct packed {
    data_t  result;
    flags_t flags;
    logic   sets_flags;
  } alu_resp_t;

endpackage

`default_nettype wire

//--- src/alu_cond_eval.sv
/* alu_cond_eval: tests a condition code against the C/O/A/S/Z/P flag word */

`default_nettype none

module alu_cond_eval (
  input  alu_pkg::flags_t flags,
  input  alu_pkg::cond_t  cond,
  output logic            taken
);

  import alu_pkg::*;

  logic s_ne_o;

  assign s_ne_o = flags.s ^ flags.o;  // signed less-than

  always_comb begin
    case (cond)
      COND_Z:      taken = flags.z;
      COND_NZ:     taken = ~flags.z;
      COND_S:      taken = flags.s;
      COND_NS:     taken = ~flags.s;
      COND_UGT:    taken = flags.c & ~flags.z;
      COND_ULE:    taken = ~flags.c | flags.z;
      COND_UGE:    taken = flags.c;
      COND_ULT:    taken = ~flags.c;
      COND_SGT:    taken = ~s_ne_o & ~flags.z;
      COND_SLE:    taken = s_ne_o | flags.z;
      COND_SGE:    taken = ~s_ne_o;
      COND_SLT:    taken = s_ne_o;
      COND_O:      taken = flags.o;
      COND_NO:     taken = ~flags.o;
      COND_P:      taken = flags.p;
      default:     taken = 1'b1;  // always
    endcase
  end

endmodule

`default_nettype wire

//--- src/alu_issue_stage.sv
/* alu_issue_stage: registers an issued operation and its valid bit,
   and predecodes the operation class for the execute stage. */

`default_nettype none

module alu_issue_stage (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  alu_pkg::alu_req_t in_req,
  output logic              iss_valid,
  output alu_pkg::alu_req_t iss_req,
  output logic              iss_is_sub,
  output logic              iss_is_logic
);

  import alu_pkg::*;

  logic dec_is_sub;
  logic dec_is_logic;

  // early class decode, keeps it off the execute path
  always_comb begin
    dec_is_sub   = 1'b0;
    dec_is_logic = 1'b0;
    case (in_req.op)
      OP_SUB64, OP_SUB32: dec_is_sub = 1'b1;
      OP_AND64, OP_AND32,
      OP_OR64,  OP_OR32,
      OP_XOR64, OP_XOR32: dec_is_logic = 1'b1;
      default: begin
        dec_is_sub   = 1'b0;
        dec_is_logic = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      iss_valid <= 1'b0;
    end else begin
      iss_valid <= in_valid;
    end
  end

  // payload, taken every cycle
  always_ff @(posedge clk) begin
    iss_req      <= in_req;
    iss_is_sub   <= dec_is_sub;
    iss_is_logic <= dec_is_logic;
  end

endmodule

`default_nettype wire

//--- src/alu_execute.sv
/* alu_execute: combinational datapath with adder, logic unit and
   conditional select; hands a raw result and carries to retire. */

`default_nettype none

module alu_execute (
  input  logic               iss_valid,
  input  alu_pkg::alu_req_t  iss_req,
  input  logic               iss_is_sub,
  input  logic               iss_is_logic,
  output logic               ex_valid,
  output alu_pkg::alu_exec_t ex_out
);

  import alu_pkg::*;

  data_t           b_in;
  logic [DATA_W:0] sum;
  data_t           logic_res;
  data_t           other_res;
  logic            cond_true;

  alu_cond_eval u_cond_eval (
    .flags (iss_req.flags_in),
    .cond  (iss_req.cond),
    .taken (cond_true)
  );

  // subtract is a + ~b + 1
  assign b_in = iss_is_sub ? ~iss_req.b : iss_req.b;
  assign sum  = {1'b0, iss_req.a} + {1'b0, b_in} + {{DATA_W{1'b0}}, iss_is_sub};

  always_comb begin
    case (iss_req.op)
      OP_AND64, OP_AND32: logic_res = iss_req.a & iss_req.b;
      OP_OR64,  OP_OR32:  logic_res = iss_req.a | iss_req.b;
      default:            logic_res = iss_req.a ^ iss_req.b;
    endcase
  end

  always_comb begin
    case (iss_req.op)
      OP_MOV64:  other_res = iss_req.b;
      OP_CMOV64: other_res = cond_true ? iss_req.b : iss_req.a;
      OP_CSET:   other_res = {{(DATA_W-1){1'b0}}, cond_true};
      default:   other_res = sum[DATA_W-1:0];  // add/sub
    endcase
  end

  assign ex_valid = iss_valid;

  always_comb begin
    ex_out.op        = iss_req.op;
    ex_out.result    = iss_is_logic ? logic_res : other_res;
    ex_out.c63       = sum[DATA_W];
    // carry into bit k+1 recovered from the sum bit
    ex_out.c31       = sum[HALF_W] ^ iss_req.a[HALF_W] ^ b_in[HALF_W];
    ex_out.c3        = sum[4] ^ iss_req.a[4] ^ b_in[4];
    ex_out.a_sign63  = iss_req.a[DATA_W-1];
    ex_out.b_sign63  = iss_req.b[DATA_W-1];
    ex_out.a_sign31  = iss_req.a[HALF_W-1];
    ex_out.b_sign31  = iss_req.b[HALF_W-1];
    ex_out.cond_true = cond_true;
    ex_out.flags_in  = iss_req.flags_in;
  end

endmodule

`default_nettype wire

//--- src/alu_retire_stage.sv
/* alu_retire_stage: truncates 32-bit results, builds the new flag word
   and registers the response with its valid bit. */

`default_nettype none

module alu_retire_stage (
  input  logic               clk,
  input  logic               rst,
  input  logic               ex_valid,
  input  alu_pkg::alu_exec_t ex_out,
  output logic               out_valid,
  output alu_pkg::alu_resp_t out_resp
);

  import alu_pkg::*;

  logic      is32;
  logic      is_sub;
  data_t     res;
  half_t     res_lo;
  logic      res_sign;
  logic      res_zero;
  logic      carry;
  logic      sign_a;
  logic      sign_b;
  logic      ovf;
  alu_resp_t resp_d;

  always_comb begin
    case (ex_out.op)
      OP_ADD32, OP_SUB32, OP_AND32, OP_OR32, OP_XOR32: is32 = 1'b1;
      default: is32 = 1'b0;
    endcase
  end

  assign is_sub = (ex_out.op == OP_SUB64) || (ex_out.op == OP_SUB32);

  assign res_lo   = ex_out.result[HALF_W-1:0];
  assign res      = is32 ? {{HALF_W{1'b0}}, res_lo} : ex_out.result;
  assign res_sign = is32 ? res[HALF_W-1] : res[DATA_W-1];
  assign res_zero = (res == '0);
  assign carry    = is32 ? ex_out.c31 : ex_out.c63;

  // b sign flips for subtract
  assign sign_a = is32 ? ex_out.a_sign31 : ex_out.a_sign63;
  assign sign_b = (is32 ? ex_out.b_sign31 : ex_out.b_sign63) ^ is_sub;
  assign ovf    = (sign_a == sign_b) && (res_sign != sign_a);

  always_comb begin
    resp_d.result = res;
    case (ex_out.op)
      OP_ADD64, OP_ADD32, OP_SUB64, OP_SUB32: begin
        resp_d.flags      = '{c: carry, o: ovf, a: ex_out.c3, s: res_sign, z: res_zero, p: 1'b0};
        resp_d.sets_flags = 1'b1;
      end
      OP_AND64, OP_AND32, OP_OR64, OP_OR32, OP_XOR64, OP_XOR32: begin
        resp_d.flags      = '{c: 1'b0, o: 1'b0, a: 1'b0, s: res_sign, z: res_zero, p: 1'b0};
        resp_d.sets_flags = 1'b1;
      end
      default: begin  // mov, cmov, cset leave flags alone
        resp_d.flags      = ex_out.flags_in;
        resp_d.sets_flags = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    out_resp <= resp_d;
  end

endmodule

`default_nettype wire

//--- src/alu_top.sv
/* alu_top: two-stage integer ALU, result two cycles after issue */

`default_nettype none

module alu_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  alu_pkg::alu_req_t  in_req,
  output logic               out_valid,
  output alu_pkg::alu_resp_t out_resp
);

  import alu_pkg::*;

  logic      iss_valid;
  alu_req_t  iss_req;
  logic      iss_is_sub;
  logic      iss_is_logic;
  logic      ex_valid;
  alu_exec_t ex_out;

  alu_issue_stage u_issue (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_req       (in_req),
    .iss_valid    (iss_valid),
    .iss_req      (iss_req),
    .iss_is_sub   (iss_is_sub),
    .iss_is_logic (iss_is_logic)
  );

  alu_execute u_execute (
    .iss_valid    (iss_valid),
    .iss_req      (iss_req),
    .iss_is_sub   (iss_is_sub),
    .iss_is_logic (iss_is_logic),
    .ex_valid     (ex_valid),
    .ex_out       (ex_out)
  );

  alu_retire_stage u_retire (
    .clk       (clk),
    .rst       (rst),
    .ex_valid  (ex_valid),
    .ex_out    (ex_out),
    .out_valid (out_valid),
    .out_resp  (out_resp)
  );

endmodule

`default_nettype wire

//--- sim/alu_tb.sv
/* alu_tb: testbench for the two-stage ALU, checks results, flags and
   latency against a reference model over directed and random ops. */

`default_nettype none

module alu_tb;

  import alu_pkg::*;

  logic      clk;
  logic      rst;
  logic      in_valid;
  alu_req_t  in_req;
  logic      out_valid;
  alu_resp_t out_resp;

  alu_resp_t exp_q[$];
  int        due_q[$];
  alu_resp_t exp_resp;
  int        due;
  int        cyc = 0;
  int        errors = 0;
  int        checks = 0;
  int        wait_cnt;
  logic [3:0] all_cond;

  alu_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_resp  (out_resp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // codes come in pairs with the odd code as the complement
  function automatic logic cond_taken(input flags_t f, input cond_t cc);
    logic [3:0] code;
    logic       lt;
    logic       base;
    code = cc;
    lt   = (f.s != f.o);
    case (code[3:1])
      3'd0: base = f.z;
      3'd1: base = f.s;
      3'd2: base = f.c && !f.z;
      3'd3: base = f.c;
      3'd4: base = !lt && !f.z;
      3'd5: base = !lt;
      3'd6: base = f.o;
      default: return (cc == COND_P) ? f.p : 1'b1;
    endcase
    return code[0] ? !base : base;
  endfunction

  function automatic alu_resp_t alu_model(input alu_req_t req);
    alu_resp_t   r;
    logic        is32;
    logic        is_sub;
    logic        is_arith;
    data_t       bi;
    data_t       raw;
    logic [64:0] wide;
    logic [32:0] lo;
    logic [4:0]  nib;
    logic        sign;
    logic        sa;
    logic        sb;
    is32     = req.op inside {OP_ADD32, OP_SUB32, OP_AND32, OP_OR32, OP_XOR32};
    is_sub   = req.op inside {OP_SUB64, OP_SUB32};
    is_arith = req.op inside {OP_ADD64, OP_ADD32, OP_SUB64, OP_SUB32};
    bi   = is_sub ? ~req.b : req.b;
    wide = {1'b0, req.a} + {1'b0, bi} + {64'd0, is_sub};
    lo   = {1'b0, req.a[31:0]} + {1'b0, bi[31:0]} + {32'd0, is_sub};
    nib  = {1'b0, req.a[3:0]} + {1'b0, bi[3:0]} + {4'd0, is_sub};
    r.flags      = req.flags_in;
    r.sets_flags = 1'b1;
    case (req.op)
      OP_AND64, OP_AND32: raw = req.a & req.b;
      OP_OR64, OP_OR32:   raw = req.a | req.b;
      OP_XOR64, OP_XOR32: raw = req.a ^ req.b;
      OP_MOV64:  raw = req.b;
      OP_CMOV64: raw = cond_taken(req.flags_in, req.cond) ? req.b : req.a;
      OP_CSET:   raw = {63'd0, cond_taken(req.flags_in, req.cond)};
      default:   raw = wide[63:0];
    endcase
    if (req.op inside {OP_MOV64, OP_CMOV64, OP_CSET}) r.sets_flags = 1'b0;
    if (is32) raw = {32'd0, raw[31:0]};
    r.result = raw;
    if (r.sets_flags) begin
      sign = is32 ? raw[31] : raw[63];
      sa   = is32 ? req.a[31] : req.a[63];
      sb   = is32 ? bi[31] : bi[63];
      r.flags = '0;
      r.flags.s = sign;
      r.flags.z = (raw == 64'd0);
      if (is_arith) begin
        r.flags.c = is32 ? lo[32] : wide[64];
        r.flags.a = nib[4];
        r.flags.o = (sa == sb) && (sign != sa);
      end
    end
    return r;
  endfunction

  function automatic alu_req_t make_req(input alu_op_t op, input cond_t cc, input data_t a,
                                        input data_t b, input flags_t f);
    alu_req_t req;
    req.op       = op;
    req.cond     = cc;
    req.a        = a;
    req.b        = b;
    req.flags_in = f;
    return req;
  endfunction

  function automatic alu_req_t random_req();
    return make_req(alu_op_t'(4'($urandom_range(0, 12))), cond_t'(4'($urandom_range(0, 15))),
                    {$urandom(), $urandom()}, {$urandom(), $urandom()},
                    flags_t'(6'($urandom())));
  endfunction

  task automatic issue_op(input alu_req_t req);
    @(posedge clk);
    in_valid <= 1'b1;
    in_req   <= req;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  // compare process samples inputs and outputs mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (out_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("out_valid rose with no operation pending at cycle %0d", cyc);
        end else begin
          exp_resp = exp_q.pop_front();
          due = due_q.pop_front();
          if (due != cyc) begin
            errors++;
            $display("result came at cycle %0d instead of cycle %0d", cyc, due);
          end
          check_value("result", out_resp.result, exp_resp.result);
          check_value("flags", {58'd0, out_resp.flags}, {58'd0, exp_resp.flags});
          check_value("sets_flags", {63'd0, out_resp.sets_flags}, {63'd0, exp_resp.sets_flags});
        end
      end else begin
        check_value("out_valid", {63'd0, out_valid}, 64'd0);
        if (due_q.size() != 0 && due_q[0] <= cyc) begin
          errors++;
          $display("no result at cycle %0d for an operation that was due", cyc);
          void'(exp_q.pop_front());
          void'(due_q.pop_front());
        end
      end
      if (in_valid) begin
        exp_q.push_back(alu_model(in_req));
        due_q.push_back(cyc + 2);  // visible half a cycle before the consumer edge
      end
    end
  end

  initial begin
    void'($urandom(32'h8229));
    rst      <= 1'b1;
    in_valid <= 1'b1;  // pipeline kept busy through reset
    in_req   <= '0;
    repeat (3) @(posedge clk);
    rst      <= 1'b0;
    in_valid <= 1'b0;
    @(negedge clk);
    check_value("out_valid", {63'd0, out_valid}, 64'd0);

    // arithmetic corners
    issue_op(make_req(OP_ADD64, COND_Z, 64'h7fff_ffff_ffff_ffff, 64'd1, '0));
    issue_op(make_req(OP_SUB64, COND_Z, 64'h1234, 64'h1234, '0));
    issue_op(make_req(OP_SUB32, COND_Z, 64'hffff_0000_0000_5555, 64'h5555, '0));
    issue_op(make_req(OP_ADD32, COND_Z, 64'h0000_0000_ffff_ffff, 64'd1, '0));
    issue_op(make_req(OP_ADD64, COND_Z, 64'h0000_0000_ffff_ffff, 64'd1, '0));
    issue_op(make_req(OP_SUB32, COND_Z, 64'h8000_0000, 64'd1, '0));
    issue_op(make_req(OP_ADD64, COND_Z, 64'h0f, 64'd1, '0));
    issue_op(make_req(OP_SUB64, COND_Z, 64'd0, 64'd1, '0));
    for (int i = 0; i < 40; i++) begin
      issue_op(make_req(alu_op_t'(4'($urandom_range(0, 3))), COND_Z,
                        {$urandom(), $urandom()}, {$urandom(), $urandom()}, '0));
    end

    // logic ops with the upper half set to catch truncation
    for (int i = 4; i <= 9; i++) begin
      issue_op(make_req(alu_op_t'(4'(i)), COND_Z, 64'hf0f0_1234_ff00_aa55,
                        64'h0ff0_8765_0f0f_aa55, '1));
    end
    idle_cycle();

    // every condition code with both conditional ops
    for (int i = 0; i < 16; i++) begin
      all_cond = 4'(i);
      issue_op(make_req(OP_CMOV64, cond_t'(all_cond), 64'haaaa, 64'hbbbb,
                        flags_t'(6'($urandom()))));
      issue_op(make_req(OP_CSET, cond_t'(all_cond), 64'haaaa, 64'hbbbb,
                        flags_t'(6'($urandom()))));
    end
    issue_op(make_req(OP_MOV64, COND_Z, 64'd5, 64'hdead_beef, 6'h2a));
    idle_cycle();

    // random burst with idle gaps
    for (int i = 0; i < 50; i++) begin
      if ($urandom_range(0, 3) == 0) idle_cycle();
      issue_op(random_req());
    end
    idle_cycle();

    wait_cnt = 0;
    while (exp_q.size() != 0 && wait_cnt < 20) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("timeout, no result arrived for %0d pending operations", exp_q.size());
    end
    repeat (4) @(negedge clk);  // catch stray results

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
src/alu_pkg.sv
src/alu_cond_eval.sv
src/alu_issue_stage.sv
src/alu_execute.sv
src/alu_retire_stage.sv
src/alu_top.sv
sim/alu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the ALU testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module alu_tb -f project.f -o alu_sim
out=$(./obj_dir/alu_sim)
echo "$out"
if echo "$out" | grep -qx "PASS: all tests"; then
  exit 0
fi
exit 1
